// File: rtl/ob_pkg.sv
// shared sizes and enums for the order book
// operation, side, status and controller state types

package ob_pkg;

    // default book geometry, overridden from the top level
    localparam int DEF_NUM_STOCKS = 4;
    localparam int DEF_BOOK_DEPTH = 8;

    // entry field widths, fixed by the port format
    localparam int PRICE_WIDTH = 32;
    localparam int QTY_WIDTH   = 16;
    localparam int ID_WIDTH    = 32;

    typedef enum logic [1:0] {
        OP_ADD     = 2'd0,
        OP_CANCEL  = 2'd1,
        OP_EXECUTE = 2'd2
    } order_op_t;

    typedef enum logic {
        SIDE_ASK = 1'b0,
        SIDE_BID = 1'b1
    } side_t;

    typedef enum logic [1:0] {
        STATUS_OK        = 2'd0,
        STATUS_FULL      = 2'd1,
        STATUS_NOT_FOUND = 2'd2
    } status_t;

    // request sequencing in order_book_ctrl
    typedef enum logic [2:0] {
        ST_IDLE   = 3'd0,
        ST_ADD    = 3'd1,
        ST_SEARCH = 3'd2,
        ST_SHIFT  = 3'd3,
        ST_SCAN   = 3'd4,
        ST_DONE   = 3'd5
    } ctrl_state_t;

endpackage

// File: rtl/book_side_store.sv
// one side of the book for every stock
// entry arrays with append, quantity update, shift-down and per-stock counts

module book_side_store
    import ob_pkg::*;
#(
    parameter int NUM_STOCKS = DEF_NUM_STOCKS,
    parameter int BOOK_DEPTH = DEF_BOOK_DEPTH,
    localparam int STOCK_W = (NUM_STOCKS > 1) ? $clog2(NUM_STOCKS) : 1,
    localparam int SLOT_W  = (BOOK_DEPTH > 1) ? $clog2(BOOK_DEPTH) : 1,
    localparam int CNT_W   = $clog2(BOOK_DEPTH + 1)
) (
    input  logic                   i_clk,
    input  logic                   i_reset_n,
    input  logic [STOCK_W-1:0]     i_stock,
    input  logic [SLOT_W-1:0]      i_slot,
    input  logic                   i_append,
    input  logic [QTY_WIDTH-1:0]   i_qty,
    input  logic [PRICE_WIDTH-1:0] i_price,
    input  logic [ID_WIDTH-1:0]    i_id,
    input  logic                   i_set_qty,
    input  logic [QTY_WIDTH-1:0]   i_new_qty,
    input  logic                   i_shift,
    input  logic                   i_drop,
    output logic [QTY_WIDTH-1:0]   o_rd_qty,
    output logic [PRICE_WIDTH-1:0] o_rd_price,
    output logic [ID_WIDTH-1:0]    o_rd_id,
    output logic [CNT_W-1:0]       o_count
);

    logic [QTY_WIDTH-1:0]   qty_mem   [NUM_STOCKS][BOOK_DEPTH];
    logic [PRICE_WIDTH-1:0] price_mem [NUM_STOCKS][BOOK_DEPTH];
    logic [ID_WIDTH-1:0]    id_mem    [NUM_STOCKS][BOOK_DEPTH];

    logic [CNT_W-1:0] count_q [NUM_STOCKS];

    logic [SLOT_W-1:0] app_slot;
    logic [SLOT_W-1:0] next_slot;
    logic              shift_ok;

    // new orders go to the first free slot of the stock
    assign app_slot  = count_q[i_stock][SLOT_W-1:0];
    assign next_slot = i_slot + 1'b1;

    // the last slot has nothing above it to pull down
    assign shift_ok = (int'(i_slot) < BOOK_DEPTH - 1);

    always_ff @(posedge i_clk) begin
        if (!i_reset_n) begin
            for (int s = 0; s < NUM_STOCKS; s++) begin
                count_q[s] <= '0;
            end
        end else if (i_append) begin
            count_q[i_stock] <= count_q[i_stock] + 1'b1;
        end else if (i_drop) begin
            count_q[i_stock] <= count_q[i_stock] - 1'b1;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_append) begin
            qty_mem[i_stock][app_slot]   <= i_qty;
            price_mem[i_stock][app_slot] <= i_price;
            id_mem[i_stock][app_slot]    <= i_id;
        end else if (i_set_qty) begin
            // partial fill keeps price and id
            qty_mem[i_stock][i_slot] <= i_new_qty;
        end else if (i_shift && shift_ok) begin
            qty_mem[i_stock][i_slot]   <= qty_mem[i_stock][next_slot];
            price_mem[i_stock][i_slot] <= price_mem[i_stock][next_slot];
            id_mem[i_stock][i_slot]    <= id_mem[i_stock][next_slot];
        end
    end

    // read port follows the slot index in the same cycle
    assign o_rd_qty   = qty_mem[i_stock][i_slot];
    assign o_rd_price = price_mem[i_stock][i_slot];
    assign o_rd_id    = id_mem[i_stock][i_slot];
    assign o_count    = count_q[i_stock];

endmodule

// File: rtl/order_book_ctrl.sv
// request sequencer for the order book
// capture, id search, removal shift, partial fill and best-price rescan

module order_book_ctrl
    import ob_pkg::*;
#(
    parameter int NUM_STOCKS = DEF_NUM_STOCKS,
    parameter int BOOK_DEPTH = DEF_BOOK_DEPTH,
    localparam int STOCK_W = (NUM_STOCKS > 1) ? $clog2(NUM_STOCKS) : 1,
    localparam int SLOT_W  = (BOOK_DEPTH > 1) ? $clog2(BOOK_DEPTH) : 1,
    localparam int CNT_W   = $clog2(BOOK_DEPTH + 1)
) (
    input  logic                   i_clk,
    input  logic                   i_reset_n,
    input  logic                   i_order_valid,
    input  order_op_t              i_order_op,
    input  side_t                  i_side,
    input  logic [STOCK_W-1:0]     i_stock_id,
    input  logic [QTY_WIDTH-1:0]   i_quantity,
    input  logic [PRICE_WIDTH-1:0] i_price,
    input  logic [ID_WIDTH-1:0]    i_order_id,
    input  logic [QTY_WIDTH-1:0]   i_rd_qty,
    input  logic [PRICE_WIDTH-1:0] i_rd_price,
    input  logic [ID_WIDTH-1:0]    i_rd_id,
    input  logic [CNT_W-1:0]       i_count,
    output logic [STOCK_W-1:0]     o_stock,
    output side_t                  o_side,
    output logic [SLOT_W-1:0]      o_slot,
    output logic                   o_append,
    output logic [QTY_WIDTH-1:0]   o_qty,
    output logic [PRICE_WIDTH-1:0] o_price,
    output logic [ID_WIDTH-1:0]    o_id,
    output logic                   o_set_qty,
    output logic [QTY_WIDTH-1:0]   o_new_qty,
    output logic                   o_shift,
    output logic                   o_drop,
    output logic                   o_scan_start,
    output logic                   o_scan_step,
    output logic [PRICE_WIDTH-1:0] o_scan_price,
    output logic                   o_scan_finish,
    output logic                   o_busy,
    output logic                   o_data_valid,
    output status_t                o_status
);

    ctrl_state_t state_q, state_d;
    status_t     status_q, status_d;

    // slot counter is one bit wider so the scan can reach a full count
    logic [CNT_W-1:0] slot_q, slot_d;
    logic [CNT_W-1:0] slot_nxt;

    // captured request
    order_op_t              op_q;
    side_t                  side_q;
    logic [STOCK_W-1:0]     stock_q;
    logic [QTY_WIDTH-1:0]   qty_q;
    logic [PRICE_WIDTH-1:0] price_q;
    logic [ID_WIDTH-1:0]    id_q;

    logic accept;
    logic id_hit;

    assign accept   = i_order_valid && (state_q == ST_IDLE);
    assign slot_nxt = slot_q + 1'b1;
    assign id_hit   = (slot_q < i_count) && (i_rd_id == id_q);

    always_comb begin
        state_d       = state_q;
        status_d      = status_q;
        slot_d        = slot_q;
        o_append      = 1'b0;
        o_set_qty     = 1'b0;
        o_shift       = 1'b0;
        o_drop        = 1'b0;
        o_scan_start  = 1'b0;
        o_scan_step   = 1'b0;
        o_scan_finish = 1'b0;

        case (state_q)
            ST_IDLE: begin
                if (accept) begin
                    slot_d  = '0;
                    state_d = (i_order_op == OP_ADD) ? ST_ADD : ST_SEARCH;
                end
            end
            ST_ADD: begin
                if (i_count == CNT_W'(BOOK_DEPTH)) begin
                    status_d = STATUS_FULL;
                    state_d  = ST_DONE;
                end else begin
                    o_append     = 1'b1;
                    o_scan_start = 1'b1;
                    status_d     = STATUS_OK;
                    slot_d       = '0;
                    state_d      = ST_SCAN;
                end
            end
            ST_SEARCH: begin
                if (id_hit) begin
                    status_d = STATUS_OK;
                    if (op_q == OP_EXECUTE && qty_q < i_rd_qty) begin
                        // partial fill, order stays where it is
                        o_set_qty    = 1'b1;
                        o_scan_start = 1'b1;
                        slot_d       = '0;
                        state_d      = ST_SCAN;
                    end else begin
                        state_d = ST_SHIFT;
                    end
                end else if (slot_nxt >= i_count) begin
                    status_d = STATUS_NOT_FOUND;
                    state_d  = ST_DONE;
                end else begin
                    slot_d = slot_nxt;
                end
            end
            ST_SHIFT: begin
                if (slot_nxt < i_count) begin
                    o_shift = 1'b1;
                    slot_d  = slot_nxt;
                end else begin
                    // top entry is now a duplicate, release it
                    o_drop       = 1'b1;
                    o_scan_start = 1'b1;
                    slot_d       = '0;
                    state_d      = ST_SCAN;
                end
            end
            ST_SCAN: begin
                if (slot_q < i_count) begin
                    o_scan_step = 1'b1;
                    slot_d      = slot_nxt;
                end else begin
                    o_scan_finish = 1'b1;
                    state_d       = ST_DONE;
                end
            end
            ST_DONE: begin
                state_d = ST_IDLE;
            end
            default: begin
                state_d = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (!i_reset_n) begin
            state_q  <= ST_IDLE;
            status_q <= STATUS_OK;
            slot_q   <= '0;
        end else begin
            state_q  <= state_d;
            status_q <= status_d;
            slot_q   <= slot_d;
        end
    end

    always_ff @(posedge i_clk) begin
        if (accept) begin
            op_q    <= i_order_op;
            side_q  <= i_side;
            stock_q <= i_stock_id;
            qty_q   <= i_quantity;
            price_q <= i_price;
            id_q    <= i_order_id;
        end
    end

    assign o_stock      = stock_q;
    assign o_side       = side_q;
    assign o_slot       = slot_q[SLOT_W-1:0];
    assign o_qty        = qty_q;
    assign o_price      = price_q;
    assign o_id         = id_q;
    assign o_new_qty    = i_rd_qty - qty_q;
    assign o_scan_price = i_rd_price;
    assign o_busy       = (state_q != ST_IDLE);
    assign o_data_valid = (state_q == ST_DONE);
    assign o_status     = status_q;

endmodule

// File: rtl/best_price_scan.sv
// running best-price compare during a rescan
// per-stock best bid and best ask cache with query read-out

module best_price_scan
    import ob_pkg::*;
#(
    parameter int NUM_STOCKS = DEF_NUM_STOCKS,
    localparam int STOCK_W = (NUM_STOCKS > 1) ? $clog2(NUM_STOCKS) : 1
) (
    input  logic                   i_clk,
    input  logic                   i_reset_n,
    input  side_t                  i_side,
    input  logic [STOCK_W-1:0]     i_stock,
    input  logic                   i_start,
    input  logic                   i_step,
    input  logic [PRICE_WIDTH-1:0] i_price,
    input  logic                   i_finish,
    input  logic [STOCK_W-1:0]     i_query_stock,
    output logic [PRICE_WIDTH-1:0] o_best_bid,
    output logic [PRICE_WIDTH-1:0] o_best_ask
);

    logic [PRICE_WIDTH-1:0] run_q;
    logic [PRICE_WIDTH-1:0] bid_cache [NUM_STOCKS];
    logic [PRICE_WIDTH-1:0] ask_cache [NUM_STOCKS];

    logic better;

    // bids want the highest price, asks the lowest
    assign better = (i_side == SIDE_BID) ? (i_price > run_q) : (i_price < run_q);

    always_ff @(posedge i_clk) begin
        if (i_start) begin
            run_q <= (i_side == SIDE_BID) ? '0 : '1;
        end else if (i_step && better) begin
            run_q <= i_price;
        end
    end

    // empty sides read as 0 for bids and all ones for asks
    always_ff @(posedge i_clk) begin
        if (!i_reset_n) begin
            for (int s = 0; s < NUM_STOCKS; s++) begin
                bid_cache[s] <= '0;
                ask_cache[s] <= '1;
            end
        end else if (i_finish) begin
            if (i_side == SIDE_BID) begin
                bid_cache[i_stock] <= run_q;
            end else begin
                ask_cache[i_stock] <= run_q;
            end
        end
    end

    assign o_best_bid = bid_cache[i_query_stock];
    assign o_best_ask = ask_cache[i_query_stock];

endmodule

// File: rtl/order_book_top.sv
// order book top level
// controller, bid and ask stores and best-price tracker

module order_book_top
    import ob_pkg::*;
#(
    parameter int NUM_STOCKS = DEF_NUM_STOCKS,
    parameter int BOOK_DEPTH = DEF_BOOK_DEPTH,
    localparam int STOCK_W = (NUM_STOCKS > 1) ? $clog2(NUM_STOCKS) : 1,
    localparam int SLOT_W  = (BOOK_DEPTH > 1) ? $clog2(BOOK_DEPTH) : 1,
    localparam int CNT_W   = $clog2(BOOK_DEPTH + 1)
) (
    input  logic                   i_clk,
    input  logic                   i_reset_n,
    input  logic                   i_order_valid,
    input  order_op_t              i_order_op,
    input  side_t                  i_side,
    input  logic [STOCK_W-1:0]     i_stock_id,
    input  logic [QTY_WIDTH-1:0]   i_quantity,
    input  logic [PRICE_WIDTH-1:0] i_price,
    input  logic [ID_WIDTH-1:0]    i_order_id,
    input  logic [STOCK_W-1:0]     i_query_stock,
    output logic                   o_book_is_busy,
    output logic                   o_data_valid,
    output status_t                o_status,
    output logic [PRICE_WIDTH-1:0] o_best_bid,
    output logic [PRICE_WIDTH-1:0] o_best_ask
);

    logic [STOCK_W-1:0]     stock;
    side_t                  side;
    logic [SLOT_W-1:0]      slot;
    logic                   append;
    logic [QTY_WIDTH-1:0]   qty;
    logic [PRICE_WIDTH-1:0] price;
    logic [ID_WIDTH-1:0]    id;
    logic                   set_qty;
    logic [QTY_WIDTH-1:0]   new_qty;
    logic                   shift;
    logic                   drop;
    logic                   scan_start;
    logic                   scan_step;
    logic [PRICE_WIDTH-1:0] scan_price;
    logic                   scan_finish;

    logic                   is_bid;

    // read data from the store of the captured side
    logic [QTY_WIDTH-1:0]   rd_qty, bid_rd_qty, ask_rd_qty;
    logic [PRICE_WIDTH-1:0] rd_price, bid_rd_price, ask_rd_price;
    logic [ID_WIDTH-1:0]    rd_id, bid_rd_id, ask_rd_id;
    logic [CNT_W-1:0]       count, bid_count, ask_count;

    assign is_bid   = (side == SIDE_BID);
    assign rd_qty   = is_bid ? bid_rd_qty : ask_rd_qty;
    assign rd_price = is_bid ? bid_rd_price : ask_rd_price;
    assign rd_id    = is_bid ? bid_rd_id : ask_rd_id;
    assign count    = is_bid ? bid_count : ask_count;

    order_book_ctrl #(
        .NUM_STOCKS (NUM_STOCKS),
        .BOOK_DEPTH (BOOK_DEPTH)
    ) order_book_ctrl_inst (
        .i_clk         (i_clk),
        .i_reset_n     (i_reset_n),
        .i_order_valid (i_order_valid),
        .i_order_op    (i_order_op),
        .i_side        (i_side),
        .i_stock_id    (i_stock_id),
        .i_quantity    (i_quantity),
        .i_price       (i_price),
        .i_order_id    (i_order_id),
        .i_rd_qty      (rd_qty),
        .i_rd_price    (rd_price),
        .i_rd_id       (rd_id),
        .i_count       (count),
        .o_stock       (stock),
        .o_side        (side),
        .o_slot        (slot),
        .o_append      (append),
        .o_qty         (qty),
        .o_price       (price),
        .o_id          (id),
        .o_set_qty     (set_qty),
        .o_new_qty     (new_qty),
        .o_shift       (shift),
        .o_drop        (drop),
        .o_scan_start  (scan_start),
        .o_scan_step   (scan_step),
        .o_scan_price  (scan_price),
        .o_scan_finish (scan_finish),
        .o_busy        (o_book_is_busy),
        .o_data_valid  (o_data_valid),
        .o_status      (o_status)
    );

    // write strobes reach only the store of the captured side
    book_side_store #(
        .NUM_STOCKS (NUM_STOCKS),
        .BOOK_DEPTH (BOOK_DEPTH)
    ) bid_store_inst (
        .i_clk      (i_clk),
        .i_reset_n  (i_reset_n),
        .i_stock    (stock),
        .i_slot     (slot),
        .i_append   (append && is_bid),
        .i_qty      (qty),
        .i_price    (price),
        .i_id       (id),
        .i_set_qty  (set_qty && is_bid),
        .i_new_qty  (new_qty),
        .i_shift    (shift && is_bid),
        .i_drop     (drop && is_bid),
        .o_rd_qty   (bid_rd_qty),
        .o_rd_price (bid_rd_price),
        .o_rd_id    (bid_rd_id),
        .o_count    (bid_count)
    );

    book_side_store #(
        .NUM_STOCKS (NUM_STOCKS),
        .BOOK_DEPTH (BOOK_DEPTH)
    ) ask_store_inst (
        .i_clk      (i_clk),
        .i_reset_n  (i_reset_n),
        .i_stock    (stock),
        .i_slot     (slot),
        .i_append   (append && !is_bid),
        .i_qty      (qty),
        .i_price    (price),
        .i_id       (id),
        .i_set_qty  (set_qty && !is_bid),
        .i_new_qty  (new_qty),
        .i_shift    (shift && !is_bid),
        .i_drop     (drop && !is_bid),
        .o_rd_qty   (ask_rd_qty),
        .o_rd_price (ask_rd_price),
        .o_rd_id    (ask_rd_id),
        .o_count    (ask_count)
    );

    best_price_scan #(
        .NUM_STOCKS (NUM_STOCKS)
    ) best_price_scan_inst (
        .i_clk         (i_clk),
        .i_reset_n     (i_reset_n),
        .i_side        (side),
        .i_stock       (stock),
        .i_start       (scan_start),
        .i_step        (scan_step),
        .i_price       (scan_price),
        .i_finish      (scan_finish),
        .i_query_stock (i_query_stock),
        .o_best_bid    (o_best_bid),
        .o_best_ask    (o_best_ask)
    );

endmodule

// File: tests/order_book_tasks.svh
// request driver, completion wait and result checks
// directed tests for adds, cancel, execute, full side and a random sequence

task automatic check_equal(input logic [31:0] got, input logic [31:0] exp,
                           input string what);
    assert (got === exp) else begin
        $display("mismatch at %0t ns: %s got 0x%0h expected 0x%0h", $time, what, got, exp);
        errors++;
    end
endtask

// one-cycle strobe, driven just after the rising edge
task automatic send_request(input order_op_t op, input side_t side, input int stock,
                            input int qty, input logic [31:0] price, input int id);
    @(posedge i_clk);
    #1;
    i_order_valid = 1'b1;
    i_order_op    = op;
    i_side        = side;
    i_stock_id    = STOCK_W'(stock);
    i_quantity    = QTY_WIDTH'(qty);
    i_price       = price;
    i_order_id    = ID_WIDTH'(id);
    @(posedge i_clk);
    #1;
    i_order_valid = 1'b0;
    check_equal(32'(o_book_is_busy), 32'd1, "busy after accept");
endtask

task automatic wait_done(output status_t st, output bit seen);
    int cycles;
    seen   = 1'b0;
    st     = STATUS_OK;
    cycles = 0;
    while (!seen && cycles < WAIT_LIMIT) begin
        @(posedge i_clk);
        #2;
        cycles++;
        if (o_data_valid) begin
            seen = 1'b1;
            st   = o_status;
            check_equal(32'(o_book_is_busy), 32'd1, "busy during completion");
        end
    end
    if (!seen) begin
        $display("timeout at %0t ns: no completion pulse within %0d cycles", $time, cycles);
        errors++;
    end
endtask

// reads the query port away from the clock edges
task automatic expect_bests(input int stock, input logic [31:0] bid,
                            input logic [31:0] ask, input string tag);
    @(posedge i_clk);
    #1;
    i_query_stock = STOCK_W'(stock);
    #4;
    check_equal(o_best_bid, bid, $sformatf("%s best bid stock %0d", tag, stock));
    check_equal(o_best_ask, ask, $sformatf("%s best ask stock %0d", tag, stock));
endtask

task automatic check_all_bests(input string tag);
    for (int s = 0; s < NUM_STOCKS; s++) begin
        expect_bests(s, model_best(s, SIDE_BID), model_best(s, SIDE_ASK), tag);
    end
endtask

task automatic do_order(input order_op_t op, input side_t side, input int stock,
                        input int qty, input logic [31:0] price, input int id,
                        input string tag, output status_t got);
    status_t exp_st;
    bit      seen;
    exp_st = model_apply(op, side, stock, qty, price, id);
    send_request(op, side, stock, qty, price, id);
    wait_done(got, seen);
    if (seen) begin
        check_equal(32'(got), 32'(exp_st), {tag, " status"});
    end
    check_all_bests(tag);
endtask

// directed step with a status fixed by the test itself
task automatic order_expect(input order_op_t op, input side_t side, input int stock,
                            input int qty, input logic [31:0] price, input int id,
                            input status_t want, input string tag);
    status_t got;
    do_order(op, side, stock, qty, price, id, tag, got);
    check_equal(32'(got), 32'(want), {tag, " expected status"});
endtask

task automatic report_test(input string name, input int errs_before);
    int n;
    n = errors - errs_before;
    tests_run++;
    if (n == 0) begin
        $display("test %s: ok", name);
    end else begin
        tests_failed++;
        $display("test %s: %0d errors", name, n);
    end
endtask

task automatic test_adds();
    int e0;
    e0 = errors;
    order_expect(OP_ADD, SIDE_BID, 1, 10, 32'd100, 101, STATUS_OK, "add bid 101");
    order_expect(OP_ADD, SIDE_BID, 1, 5, 32'd120, 102, STATUS_OK, "add bid 102");
    order_expect(OP_ADD, SIDE_BID, 1, 7, 32'd110, 103, STATUS_OK, "add bid 103");
    order_expect(OP_ADD, SIDE_ASK, 1, 8, 32'd130, 201, STATUS_OK, "add ask 201");
    order_expect(OP_ADD, SIDE_ASK, 1, 4, 32'd125, 202, STATUS_OK, "add ask 202");
    order_expect(OP_ADD, SIDE_ASK, 1, 6, 32'd140, 203, STATUS_OK, "add ask 203");
    expect_bests(1, 32'd120, 32'd125, "after adds");
    report_test("adds_both_sides", e0);
endtask

task automatic test_cancel();
    int e0;
    e0 = errors;
    order_expect(OP_CANCEL, SIDE_BID, 1, 0, 32'd0, 102, STATUS_OK, "cancel best bid");
    expect_bests(1, 32'd110, 32'd125, "after best bid cancel");
    order_expect(OP_CANCEL, SIDE_BID, 1, 0, 32'd0, 999, STATUS_NOT_FOUND, "cancel unknown");
    expect_bests(1, 32'd110, 32'd125, "after unknown cancel");
    order_expect(OP_ADD, SIDE_ASK, 2, 3, 32'd90, 301, STATUS_OK, "add ask 301");
    expect_bests(2, 32'd0, 32'd90, "single ask");
    order_expect(OP_CANCEL, SIDE_ASK, 2, 0, 32'd0, 301, STATUS_OK, "cancel last ask");
    expect_bests(2, 32'd0, 32'hFFFF_FFFF, "empty ask side");
    report_test("cancel", e0);
endtask

task automatic test_execute();
    int e0;
    e0 = errors;
    // ask 202 rests with quantity 4
    order_expect(OP_EXECUTE, SIDE_ASK, 1, 3, 32'd0, 202, STATUS_OK, "partial execute");
    expect_bests(1, 32'd110, 32'd125, "after partial execute");
    order_expect(OP_EXECUTE, SIDE_ASK, 1, 1, 32'd0, 202, STATUS_OK, "final execute");
    expect_bests(1, 32'd110, 32'd130, "after final execute");
    report_test("execute", e0);
endtask

task automatic test_full_side();
    int e0;
    e0 = errors;
    for (int i = 0; i < BOOK_DEPTH; i++) begin
        order_expect(OP_ADD, SIDE_BID, 3, 2, 32'd50 + 32'(i), 400 + i, STATUS_OK,
                     $sformatf("fill bid %0d", i));
    end
    order_expect(OP_ADD, SIDE_BID, 3, 2, 32'd99, 499, STATUS_FULL, "add to full side");
    expect_bests(3, 32'd50 + 32'(BOOK_DEPTH - 1), 32'hFFFF_FFFF, "full stock");
    expect_bests(1, 32'd110, 32'd130, "other stock");
    report_test("full_side", e0);
endtask

task automatic test_random();
    int          e0;
    logic [31:0] r;
    order_op_t   op;
    side_t       side;
    int          stock;
    int          qty;
    logic [31:0] price;
    int          n;
    int          id;
    int          next_id;
    status_t     got;
    e0      = errors;
    next_id = 5000;
    for (int k = 0; k < RAND_OPS; k++) begin
        r     = rand_bits(2);
        side  = (rand_bits(1) != 0) ? SIDE_BID : SIDE_ASK;
        stock = int'(rand_bits(8) % NUM_STOCKS);
        qty   = 1 + int'(rand_bits(4));
        price = 32'd100 + rand_bits(6);
        n     = m_cnt[stock][int'(side)];
        if (r == 0 || r == 3) begin
            op = OP_ADD;
            id = next_id;
            next_id++;
        end else begin
            op = (r == 1) ? OP_CANCEL : OP_EXECUTE;
            // mostly resting ids, sometimes one that never existed
            if (n > 0 && rand_bits(2) != 0) begin
                id = m_id[stock][int'(side)][int'(rand_bits(3)) % n];
            end else begin
                id = 9000 + int'(rand_bits(4));
            end
        end
        do_order(op, side, stock, qty, price, id, $sformatf("random op %0d", k), got);
    end
    report_test("random_sequence", e0);
endtask

// File: tests/order_book_tb.sv
// testbench top for the order book
// clock, reset, DUT instance, LFSR, reference model and test sequence

module order_book_tb
    import ob_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_STOCKS = 4;
    localparam int BOOK_DEPTH = 8;
    localparam int STOCK_W    = $clog2(NUM_STOCKS);
    localparam int WAIT_LIMIT = 200;
    localparam int RAND_OPS   = 80;

    logic                   i_clk;
    logic                   i_reset_n;
    logic                   i_order_valid;
    order_op_t              i_order_op;
    side_t                  i_side;
    logic [STOCK_W-1:0]     i_stock_id;
    logic [QTY_WIDTH-1:0]   i_quantity;
    logic [PRICE_WIDTH-1:0] i_price;
    logic [ID_WIDTH-1:0]    i_order_id;
    logic [STOCK_W-1:0]     i_query_stock;
    logic                   o_book_is_busy;
    logic                   o_data_valid;
    status_t                o_status;
    logic [PRICE_WIDTH-1:0] o_best_bid;
    logic [PRICE_WIDTH-1:0] o_best_ask;

    int errors;
    int tests_run;
    int tests_failed;

    logic [31:0] lfsr_state;

    // reference book, indexed by stock, side and slot in arrival order
    int          m_qty   [NUM_STOCKS][2][BOOK_DEPTH];
    logic [31:0] m_price [NUM_STOCKS][2][BOOK_DEPTH];
    int          m_id    [NUM_STOCKS][2][BOOK_DEPTH];
    int          m_cnt   [NUM_STOCKS][2];

    order_book_top #(
        .NUM_STOCKS (NUM_STOCKS),
        .BOOK_DEPTH (BOOK_DEPTH)
    ) order_book_top_inst (
        .i_clk          (i_clk),
        .i_reset_n      (i_reset_n),
        .i_order_valid  (i_order_valid),
        .i_order_op     (i_order_op),
        .i_side         (i_side),
        .i_stock_id     (i_stock_id),
        .i_quantity     (i_quantity),
        .i_price        (i_price),
        .i_order_id     (i_order_id),
        .i_query_stock  (i_query_stock),
        .o_book_is_busy (o_book_is_busy),
        .o_data_valid   (o_data_valid),
        .o_status       (o_status),
        .o_best_bid     (o_best_bid),
        .o_best_ask     (o_best_ask)
    );

    // galois form, taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    // one LFSR step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsr_state[0]};
            lfsr_state = lfsr_step(lfsr_state);
        end
        return r;
    endfunction

    function automatic void model_clear();
        for (int s = 0; s < NUM_STOCKS; s++) begin
            m_cnt[s][0] = 0;
            m_cnt[s][1] = 0;
        end
    endfunction

    // applies one request to the reference book and returns its status
    function automatic status_t model_apply(input order_op_t op, input side_t side,
                                            input int stock, input int qty,
                                            input logic [31:0] price, input int id);
        int sd;
        int n;
        int hit;
        sd = int'(side);
        n = m_cnt[stock][sd];
        if (op == OP_ADD) begin
            if (n == BOOK_DEPTH) begin
                return STATUS_FULL;
            end
            m_qty[stock][sd][n]   = qty;
            m_price[stock][sd][n] = price;
            m_id[stock][sd][n]    = id;
            m_cnt[stock][sd]      = n + 1;
            return STATUS_OK;
        end
        hit = -1;
        for (int i = 0; i < n; i++) begin
            if (hit < 0 && m_id[stock][sd][i] == id) begin
                hit = i;
            end
        end
        if (hit < 0) begin
            return STATUS_NOT_FOUND;
        end
        if (op == OP_EXECUTE && qty < m_qty[stock][sd][hit]) begin
            m_qty[stock][sd][hit] = m_qty[stock][sd][hit] - qty;
            return STATUS_OK;
        end
        // removal keeps the later orders in arrival order
        for (int i = hit; i < n - 1; i++) begin
            m_qty[stock][sd][i]   = m_qty[stock][sd][i+1];
            m_price[stock][sd][i] = m_price[stock][sd][i+1];
            m_id[stock][sd][i]    = m_id[stock][sd][i+1];
        end
        m_cnt[stock][sd] = n - 1;
        return STATUS_OK;
    endfunction

    // highest bid or lowest ask, empty sides give 0 and all ones
    function automatic logic [31:0] model_best(input int stock, input side_t side);
        logic [31:0] b;
        int sd;
        sd = int'(side);
        b = (side == SIDE_BID) ? 32'h0 : 32'hFFFF_FFFF;
        for (int i = 0; i < m_cnt[stock][sd]; i++) begin
            if (side == SIDE_BID && m_price[stock][sd][i] > b) begin
                b = m_price[stock][sd][i];
            end else if (side == SIDE_ASK && m_price[stock][sd][i] < b) begin
                b = m_price[stock][sd][i];
            end
        end
        return b;
    endfunction

    `include "order_book_tasks.svh"

    initial begin
        i_clk = 1'b0;
        forever #5 i_clk = ~i_clk;
    end

    initial begin
        i_reset_n     = 1'b0;
        i_order_valid = 1'b0;
        i_order_op    = OP_ADD;
        i_side        = SIDE_ASK;
        i_stock_id    = '0;
        i_quantity    = '0;
        i_price       = '0;
        i_order_id    = '0;
        i_query_stock = '0;
        errors        = 0;
        tests_run     = 0;
        tests_failed  = 0;
        lfsr_state    = 32'h81e0_0456;
        model_clear();

        repeat (8) @(posedge i_clk);
        #1 i_reset_n = 1'b1;

        test_adds();
        test_cancel();
        test_execute();
        test_full_side();
        test_random();

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// File: order_book.f
+incdir+tests
rtl/ob_pkg.sv
rtl/book_side_store.sv
rtl/order_book_ctrl.sv
rtl/best_price_scan.sv
rtl/order_book_top.sv
tests/order_book_tb.sv

// File: Makefile
SIM  := obj_dir/Vorder_book_tb
SRCS := rtl/ob_pkg.sv rtl/book_side_store.sv rtl/order_book_ctrl.sv \
        rtl/best_price_scan.sv rtl/order_book_top.sv \
        tests/order_book_tb.sv tests/order_book_tasks.svh

.PHONY: run clean

run: $(SIM)
	./$(SIM) | tee sim.log
	grep -q "SIMULATION PASSED" sim.log

$(SIM): $(SRCS) order_book.f
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module order_book_tb -f order_book.f

clean:
	rm -rf obj_dir sim.log
